//--- snd.f
+incdir+.
snd_pkg.sv
snd_bus_decode.sv
snd_adpcm_voice.sv
snd_mixer.sv
snd_board.sv
snd_tb.sv

//--- Bender.yml
package:
  name: snd

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - snd_pkg.sv
      - snd_bus_decode.sv
      - snd_adpcm_voice.sv
      - snd_mixer.sv
      - snd_board.sv
  - target: test
    include_dirs:
      - .
    files:
      - snd_tb.sv

//--- snd_tb.sv
////////////////////////////////////////////////////////////////////////////
// sound board testbench
// clock and reset, host bus tasks, ROM responders, ADPCM reference model,
// sound stream checks and cycle limit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "snd_params.svh"

module snd_tb;

    localparam int NV      = `SND_VOICES;
    localparam int PAGE_N  = 512;
    localparam int STOP_AT = 48;
    localparam int TAIL    = 4;
    // ticks played over tests 3 to 6
    localparam int PLAYED  = 3 * (PAGE_N + TAIL) + STOP_AT + `SND_CREDITS + TAIL;
    localparam int LIMIT   = PLAYED * `SND_TICK_DIV + 2000;

    logic                            clk;
    logic                            rst_n;
    logic                            host_cs;
    logic                            host_we;
    logic [3:0]                      host_addr;
    logic [7:0]                      host_wdata;
    logic [7:0]                      host_rdata;
    logic [7:0]                      snd_latch;
    logic                            snd_irq;
    logic                            irq_n;
    logic [NV-1:0][`SND_ROM_AW-1:0]  rom_addr;
    logic [NV-1:0]                   rom_cs;
    wire  [NV-1:0][7:0]              rom_data;
    wire  [NV-1:0]                   rom_ok;
    logic signed [15:0]              sound;
    logic                            sample;

    integer      seed;
    int          errors;
    int          checks;
    int          cycles;
    int          max_lat;
    logic [7:0]  rom_mem [NV][1 << `SND_ROM_AW];
    int          vstream [NV][1024];
    int          vlen    [NV];
    int          captured [1024];
    int          stream3  [1024];

    snd_board i_dut (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .host_cs    ( host_cs     ),
        .host_we    ( host_we     ),
        .host_addr  ( host_addr   ),
        .host_wdata ( host_wdata  ),
        .host_rdata ( host_rdata  ),
        .snd_latch  ( snd_latch   ),
        .snd_irq    ( snd_irq     ),
        .irq_n      ( irq_n       ),
        .rom_addr   ( rom_addr    ),
        .rom_cs     ( rom_cs      ),
        .rom_data   ( rom_data    ),
        .rom_ok     ( rom_ok      ),
        .sound      ( sound       ),
        .sample     ( sample      )
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: no end of test after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // one ROM per voice
    // answers after 1 to max_lat cycles
    for (genvar v = 0; v < NV; v++) begin : g_rom
        logic [7:0] rdata;
        logic       ok;
        int         lat;
        assign rom_data[v] = rdata;
        assign rom_ok[v]   = ok;
        initial begin
            rdata = 8'h00;
            ok    = 1'b0;
            forever begin
                @(negedge clk);
                if (rom_cs[v]) begin
                    lat = 1 + (($random(seed) & 32'h7fffffff) % max_lat);
                    repeat (lat) @(posedge clk);
                    #2;
                    rdata = rom_mem[v][rom_addr[v]];
                    ok    = 1'b1;
                    @(posedge clk);
                    #2;
                    ok = 1'b0;
                end
            end
        end
    end

    task automatic host_write(input logic [3:0] addr, input logic [7:0] data);
        @(posedge clk);
        #2;
        host_cs    = 1'b1;
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        @(posedge clk);
        #2;
        host_cs = 1'b0;
        host_we = 1'b0;
    endtask

    // read data taken at the falling edge
    task automatic host_read(input logic [3:0] addr, output logic [7:0] data);
        @(posedge clk);
        #2;
        host_cs   = 1'b1;
        host_we   = 1'b0;
        host_addr = addr;
        @(negedge clk);
        data = host_rdata;
        @(posedge clk);
        #2;
        host_cs = 1'b0;
    endtask

    task automatic wait_sample();
        @(negedge clk);
        while (sample !== 1'b1)
            @(negedge clk);
    endtask

    task automatic check_value(input string name, input int exp,
                               input logic signed [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    // OKI decode of one page
    // high nibble first
    task automatic decode_voice(input int v, input int page);
        int         acc;
        int         idx;
        int         step;
        int         diff;
        int         n;
        logic [7:0] b;
        logic [3:0] nib;
        acc = 0;
        idx = 0;
        n   = 0;
        for (int a = page * 256; a < page * 256 + 256; a++) begin
            b = rom_mem[v][a];
            for (int h = 0; h < 2; h++) begin
                nib  = (h == 0) ? b[7:4] : b[3:0];
                step = snd_pkg::step_table[idx];
                diff = step / 8;
                if (nib[0])
                    diff = diff + step / 4;
                if (nib[1])
                    diff = diff + step / 2;
                if (nib[2])
                    diff = diff + step;
                acc = nib[3] ? acc - diff : acc + diff;
                if (acc > 2047)
                    acc = 2047;
                if (acc < -2048)
                    acc = -2048;
                idx = idx + int'(snd_pkg::index_adjust[nib[2:0]]);
                if (idx < 0)
                    idx = 0;
                if (idx > 48)
                    idx = 48;
                vstream[v][n] = acc;
                n++;
            end
        end
        vlen[v] = n;
    endtask

    // expected sound for tick k
    // voices past their end add zero
    function automatic int mix_at(input int k);
        int s;
        s = 0;
        for (int v = 0; v < NV; v++) begin
            if (k < vlen[v])
                s = s + 8 * vstream[v][k];
        end
        if (s > 32767)
            s = 32767;
        if (s < -32768)
            s = -32768;
        return s;
    endfunction

    task automatic check_stream(input int n);
        int last;
        last = 0;
        for (int k = 0; k < n; k++) begin
            wait_sample();
            // strobes one tick period apart
            if (k > 0)
                check_value("sample period", `SND_TICK_DIV, cycles - last);
            last = cycles;
            captured[k] = sound;
            check_value("sound", mix_at(k), sound);
        end
    endtask

    task automatic report(input string name, input int err_before);
        if (errors == err_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - err_before);
    endtask

    initial begin
        logic [7:0] rd;
        logic [7:0] latch_val;
        int         e0;
        int         pg0;
        int         pg1;
        int         page3;
        int         got;
        bit         drained;
        seed       = 50289;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        max_lat    = 6;
        rst_n      = 1'b0;
        host_cs    = 1'b0;
        host_we    = 1'b0;
        host_addr  = 4'd0;
        host_wdata = 8'h00;
        snd_latch  = 8'h00;
        snd_irq    = 1'b0;
        for (int v = 0; v < NV; v++) begin
            for (int a = 0; a < (1 << `SND_ROM_AW); a++)
                rom_mem[v][a] = $random(seed);
        end
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // test 1 reset state
        e0 = errors;
        @(negedge clk);
        check_value("irq_n", 1, irq_n);
        check_value("sound", 0, sound);
        check_value("sample", 0, sample);
        check_value("rom_cs", 0, rom_cs);
        host_read(4'd1, rd);
        check_value("status", 0, rd);
        report("reset state", e0);

        // test 2 latch and irq
        // irq cleared by a read of register 0
        e0 = errors;
        latch_val = $random(seed);
        @(posedge clk);
        #2;
        snd_latch = latch_val;
        snd_irq   = 1'b1;
        @(posedge clk);
        #2;
        snd_irq = 1'b0;
        @(negedge clk);
        check_value("irq_n", 0, irq_n);
        host_read(4'd0, rd);
        check_value("host_rdata", latch_val, rd);
        @(negedge clk);
        check_value("irq_n", 1, irq_n);
        report("command latch", e0);

        // test 3 voice 0 alone
        // started right after a strobe
        e0 = errors;
        page3 = ($random(seed) & 32'h7fffffff) % 256;
        decode_voice(0, page3);
        for (int v = 1; v < NV; v++)
            vlen[v] = 0;
        host_write(4'd8, page3);
        host_write(4'd9, page3);
        wait_sample();
        host_write(4'd10, 8'h01);
        host_read(4'd1, rd);
        check_value("status", 1, rd);
        check_stream(PAGE_N + TAIL);
        host_read(4'd1, rd);
        check_value("status", 0, rd);
        for (int k = 0; k < PAGE_N + TAIL; k++)
            stream3[k] = captured[k];
        report("single voice", e0);

        // test 4 both voices
        // voice 1 driven to full scale both ways
        e0 = errors;
        pg0 = ($random(seed) & 32'h7fffffff) % 256;
        pg1 = ($random(seed) & 32'h7fffffff) % 256;
        for (int a = 0; a < 256; a++)
            rom_mem[1][pg1 * 256 + a] = (a < 128) ? 8'h77 : 8'hff;
        decode_voice(0, pg0);
        decode_voice(1, pg1);
        host_write(4'd8, pg0);
        host_write(4'd9, pg0);
        host_write(4'd12, pg1);
        host_write(4'd13, pg1);
        wait_sample();
        host_write(4'd10, 8'h01);
        host_write(4'd14, 8'h01);
        check_stream(PAGE_N + TAIL);
        host_read(4'd1, rd);
        check_value("status", 0, rd);
        report("two voices", e0);

        // test 5 stop mid page
        // buffered samples drain then zero
        e0 = errors;
        pg0 = ($random(seed) & 32'h7fffffff) % 256;
        decode_voice(0, pg0);
        for (int v = 1; v < NV; v++)
            vlen[v] = 0;
        host_write(4'd8, pg0);
        host_write(4'd9, pg0);
        wait_sample();
        host_write(4'd10, 8'h01);
        check_stream(STOP_AT);
        host_write(4'd10, 8'h00);
        host_read(4'd1, rd);
        check_value("status", 0, rd);
        drained = 1'b0;
        for (int j = 0; j < `SND_CREDITS; j++) begin
            wait_sample();
            got = sound;
            checks++;
            if (drained || got != mix_at(STOP_AT + j)) begin
                if (got != 0) begin
                    errors++;
                    $display("ERR %0t sound expected %0d or 0 got %0d", $time,
                             mix_at(STOP_AT + j), got);
                end
                drained = 1'b1;
            end
        end
        for (int j = 0; j < TAIL; j++) begin
            wait_sample();
            check_value("sound", 0, sound);
        end
        report("stop", e0);

        // test 6 replay of test 3 with slow ROM
        e0 = errors;
        max_lat = `SND_TICK_DIV / 4 - 1;
        decode_voice(0, page3);
        host_write(4'd8, page3);
        host_write(4'd9, page3);
        wait_sample();
        host_write(4'd10, 8'h01);
        check_stream(PAGE_N + TAIL);
        for (int k = 0; k < PAGE_N + TAIL; k++)
            check_value("sound", stream3[k], captured[k]);
        report("rom back-pressure", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- snd_board.sv
////////////////////////////////////////////////////////////////////////////
// sound board top level
// host bus decoder, ADPCM voices, mixer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "snd_params.svh"

module snd_board (
    input  logic                                     clk,
    input  logic                                     rst_n,
    // host register bus
    input  logic                                     host_cs,
    input  logic                                     host_we,
    input  logic [3:0]                               host_addr,
    input  logic [7:0]                               host_wdata,
    output logic [7:0]                               host_rdata,
    // main cpu
    input  logic [7:0]                               snd_latch,
    input  logic                                     snd_irq,
    output logic                                     irq_n,
    // one sample ROM per voice
    output logic [`SND_VOICES-1:0][`SND_ROM_AW-1:0]  rom_addr,
    output logic [`SND_VOICES-1:0]                   rom_cs,
    input  logic [`SND_VOICES-1:0][7:0]              rom_data,
    input  logic [`SND_VOICES-1:0]                   rom_ok,
    // mixed output
    output logic signed [15:0]                       sound,
    output logic                                     sample
);

    snd_pkg::voice_cmd_t    [`SND_VOICES-1:0]  cmd;
    snd_pkg::voice_sample_t [`SND_VOICES-1:0]  smp;
    logic [`SND_VOICES-1:0]                    busy;
    logic [`SND_VOICES-1:0]                    credit_ret;

    snd_bus_decode u_dec (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .host_cs    ( host_cs     ),
        .host_we    ( host_we     ),
        .host_addr  ( host_addr   ),
        .host_wdata ( host_wdata  ),
        .host_rdata ( host_rdata  ),
        .snd_latch  ( snd_latch   ),
        .snd_irq    ( snd_irq     ),
        .irq_n      ( irq_n       ),
        .busy       ( busy        ),
        .cmd        ( cmd         )
    );

    // identical voices, each with its own ROM
    for (genvar v = 0; v < `SND_VOICES; v++) begin : g_voice
        snd_adpcm_voice u_voice (
            .clk        ( clk            ),
            .rst_n      ( rst_n          ),
            .cmd        ( cmd[v]         ),
            .rom_addr   ( rom_addr[v]    ),
            .rom_cs     ( rom_cs[v]      ),
            .rom_data   ( rom_data[v]    ),
            .rom_ok     ( rom_ok[v]      ),
            .smp        ( smp[v]         ),
            .credit_ret ( credit_ret[v]  ),
            .busy       ( busy[v]        )
        );
    end

    snd_mixer u_mix (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .smp        ( smp         ),
        .credit_ret ( credit_ret  ),
        .sound      ( sound       ),
        .sample     ( sample      )
    );

endmodule

//--- snd_mixer.sv
////////////////////////////////////////////////////////////////////////////
// voice mixer
// per-voice sample buffers, sample rate tick, credit return,
// scaled and saturated sum
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "snd_params.svh"

module snd_mixer (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  snd_pkg::voice_sample_t [`SND_VOICES-1:0]  smp,
    output logic [`SND_VOICES-1:0]                    credit_ret,
    output logic signed [15:0]                        sound,
    output logic                                      sample
);

    localparam int DEPTH = `SND_CREDITS;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);
    localparam int TW    = $clog2(`SND_TICK_DIV);
    localparam int SW    = 17 + $clog2(`SND_VOICES);

    logic signed [11:0]    mem [`SND_VOICES][DEPTH];
    logic [PW-1:0]         wr_ptr [`SND_VOICES];
    logic [PW-1:0]         rd_ptr [`SND_VOICES];
    logic [CW-1:0]         count  [`SND_VOICES];
    logic signed [11:0]    head   [`SND_VOICES];
    logic [TW-1:0]         tick_cnt;
    logic                  tick;
    logic signed [SW-1:0]  sum;
    logic signed [15:0]    sat;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        if (p == PW'(DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    // sample rate prescaler
    assign tick = (tick_cnt == TW'(`SND_TICK_DIV - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            tick_cnt <= '0;
        else
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
    end

    // buffer pointers and fill level
    // credits keep the writer from overrunning
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < `SND_VOICES; v++) begin
                wr_ptr[v] <= '0;
                rd_ptr[v] <= '0;
                count[v]  <= '0;
            end
        end else begin
            for (int v = 0; v < `SND_VOICES; v++) begin
                if (smp[v].valid)
                    wr_ptr[v] <= ptr_inc(wr_ptr[v]);
                if (credit_ret[v])
                    rd_ptr[v] <= ptr_inc(rd_ptr[v]);
                count[v] <= count[v] + CW'(smp[v].valid) - CW'(credit_ret[v]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int v = 0; v < `SND_VOICES; v++) begin
            if (smp[v].valid)
                mem[v][wr_ptr[v]] <= smp[v].value;
        end
    end

    // pop on tick, empty buffer adds zero
    always_comb begin
        sum = '0;
        for (int v = 0; v < `SND_VOICES; v++) begin
            credit_ret[v] = tick && (count[v] != '0);
            head[v]       = (count[v] != '0) ? mem[v][rd_ptr[v]] : 12'sd0;
            // sign extend then x8
            sum = sum + (SW'(head[v]) <<< 3);
        end
        if (sum > SW'(32767))
            sat = 16'sh7fff;
        else if (sum < -SW'(32768))
            sat = -16'sh8000;
        else
            sat = sum[15:0];
    end

    // output one cycle after the tick
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sound  <= 16'sd0;
            sample <= 1'b0;
        end else begin
            sample <= tick;
            if (tick)
                sound <= sat;
        end
    end

endmodule

//--- snd_adpcm_voice.sv
////////////////////////////////////////////////////////////////////////////
// one OKI ADPCM voice
// sample ROM fetch, nibble decoder, credit counter, sample send
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "snd_params.svh"

module snd_adpcm_voice (
    input  logic                    clk,
    input  logic                    rst_n,
    input  snd_pkg::voice_cmd_t     cmd,
    // sample ROM
    output logic [`SND_ROM_AW-1:0]  rom_addr,
    output logic                    rom_cs,
    input  logic [7:0]              rom_data,
    input  logic                    rom_ok,
    // mixer side
    output snd_pkg::voice_sample_t  smp,
    input  logic                    credit_ret,
    output logic                    busy
);

    localparam int AW = `SND_ROM_AW;
    localparam int CW = $clog2(`SND_CREDITS + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_HI,
        ST_LO
    } state_t;

    state_t              state;
    logic [AW-1:0]       addr;
    logic [7:0]          end_pg;
    logic [7:0]          data_q;
    logic signed [11:0]  acc;
    logic [5:0]          idx;
    logic [CW-1:0]       credits;
    logic                smp_vld;
    logic [3:0]          nib;
    logic [11:0]         step;
    logic [11:0]         diff;
    logic signed [13:0]  acc_sum;
    logic signed [11:0]  acc_nxt;
    logic signed [6:0]   idx_sum;
    logic [5:0]          idx_nxt;
    logic                send;
    logic                last_byte;

    // high nibble first
    assign nib  = (state == ST_HI) ? data_q[7:4] : data_q[3:0];
    assign step = snd_pkg::step_table[idx];

    // OKI difference, accumulator and index update
    always_comb begin
        diff = step >> 3;
        if (nib[0])
            diff = diff + (step >> 2);
        if (nib[1])
            diff = diff + (step >> 1);
        if (nib[2])
            diff = diff + step;
        if (nib[3])
            acc_sum = $signed({{2{acc[11]}}, acc}) - $signed({2'b00, diff});
        else
            acc_sum = $signed({{2{acc[11]}}, acc}) + $signed({2'b00, diff});
        // clamp to 12-bit range
        if (acc_sum > 14'sd2047)
            acc_nxt = 12'sd2047;
        else if (acc_sum < -14'sd2048)
            acc_nxt = -12'sd2048;
        else
            acc_nxt = acc_sum[11:0];
        idx_sum = $signed({1'b0, idx}) + snd_pkg::index_adjust[nib[2:0]];
        // keep inside the step table
        if (idx_sum < 7'sd0)
            idx_nxt = 6'd0;
        else if (idx_sum > 7'sd48)
            idx_nxt = 6'd48;
        else
            idx_nxt = idx_sum[5:0];
    end

    // nothing goes out in a cycle that carries a command
    assign send = (credits != '0) && (state == ST_HI || state == ST_LO)
                  && !cmd.start && !cmd.stop;
    assign last_byte = (addr == AW'({end_pg, 8'hff}));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            addr   <= '0;
            end_pg <= 8'h00;
            acc    <= '0;
            idx    <= '0;
        end else if (cmd.start) begin
            // restart from any state
            state  <= ST_FETCH;
            addr   <= AW'({cmd.start_page, 8'h00});
            end_pg <= cmd.end_page;
            acc    <= '0;
            idx    <= '0;
        end else if (cmd.stop) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (rom_ok)
                        state <= ST_HI;
                end
                ST_HI: begin
                    if (send) begin
                        acc   <= acc_nxt;
                        idx   <= idx_nxt;
                        state <= ST_LO;
                    end
                end
                ST_LO: begin
                    if (send) begin
                        acc <= acc_nxt;
                        idx <= idx_nxt;
                        if (last_byte) begin
                            state <= ST_IDLE;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= ST_FETCH;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // rom byte capture
    always_ff @(posedge clk) begin
        if (state == ST_FETCH && rom_ok)
            data_q <= rom_data;
    end

    // credits come back from the mixer, one goes per send
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CW'(`SND_CREDITS);
            smp_vld <= 1'b0;
        end else begin
            credits <= credits + CW'(credit_ret) - CW'(send);
            smp_vld <= send;
        end
    end

    assign rom_addr = addr;
    assign rom_cs   = (state == ST_FETCH);
    assign busy     = (state != ST_IDLE);
    // acc holds the value just decoded
    assign smp      = '{valid: smp_vld, value: acc};

endmodule

//--- snd_bus_decode.sv
////////////////////////////////////////////////////////////////////////////
// host register decoder
// command latch readback, edge triggered irq flip-flop,
// per-voice page registers and start/stop pulse generation
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "snd_params.svh"

module snd_bus_decode (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // host register bus
    input  logic                                   host_cs,
    input  logic                                   host_we,
    input  logic [3:0]                             host_addr,
    input  logic [7:0]                             host_wdata,
    output logic [7:0]                             host_rdata,
    // main cpu side
    input  logic [7:0]                             snd_latch,
    input  logic                                   snd_irq,
    output logic                                   irq_n,
    // voices
    input  logic [`SND_VOICES-1:0]                 busy,
    output snd_pkg::voice_cmd_t [`SND_VOICES-1:0]  cmd
);

    logic              wr_stb;
    logic              rd_latch;
    logic              irq_q;
    logic              irq_ff;
    logic [7:0]        start_pg [`SND_VOICES];
    logic [7:0]        end_pg   [`SND_VOICES];
    snd_pkg::status_t  status;

    // single cycle strobes
    assign wr_stb   = host_cs & host_we;
    assign rd_latch = host_cs & ~host_we & (host_addr == 4'd0);

    // page registers, voice v sits at 8 + 4v
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < `SND_VOICES; v++) begin
                start_pg[v] <= 8'h00;
                end_pg[v]   <= 8'h00;
            end
        end else if (wr_stb) begin
            for (int v = 0; v < `SND_VOICES; v++) begin
                if (host_addr == 4'(8 + 4 * v))
                    start_pg[v] <= host_wdata;
                if (host_addr == 4'(9 + 4 * v))
                    end_pg[v] <= host_wdata;
            end
        end
    end

    // control write becomes a one cycle start or stop
    always_comb begin
        for (int v = 0; v < `SND_VOICES; v++) begin
            cmd[v].start_page = start_pg[v];
            cmd[v].end_page   = end_pg[v];
            cmd[v].start = wr_stb & (host_addr == 4'(10 + 4 * v)) &  host_wdata[0];
            cmd[v].stop  = wr_stb & (host_addr == 4'(10 + 4 * v)) & ~host_wdata[0];
        end
    end

    // rising edge of snd_irq sets, latch read clears
    // a new edge wins over a simultaneous read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q  <= 1'b0;
            irq_ff <= 1'b0;
        end else begin
            irq_q <= snd_irq;
            if (snd_irq && !irq_q)
                irq_ff <= 1'b1;
            else if (rd_latch)
                irq_ff <= 1'b0;
        end
    end

    assign irq_n = ~irq_ff;

    always_comb begin
        status      = '0;
        status.busy = busy;
    end

    // read mux, combinational
    always_comb begin
        case (host_addr)
            4'd0:    host_rdata = snd_latch;
            4'd1:    host_rdata = status;
            default: host_rdata = 8'h00;
        endcase
    end

endmodule

//--- snd_pkg.sv
////////////////////////////////////////////////////////////////////////////
// sound board types
// voice command, decoded sample and status structs
// OKI ADPCM step and index tables
////////////////////////////////////////////////////////////////////////////

`include "snd_params.svh"

package snd_pkg;

    // one command to a voice, start/stop are single cycle pulses
    typedef struct packed {
        logic       start;
        logic       stop;
        logic [7:0] start_page;
        logic [7:0] end_page;
    } voice_cmd_t;

    // one decoded sample
    typedef struct packed {
        logic              valid;
        logic signed [11:0] value;
    } voice_sample_t;

    // host status register, one busy bit per voice
    typedef struct packed {
        logic [7-`SND_VOICES:0]  rsvd;
        logic [`SND_VOICES-1:0]  busy;
    } status_t;

    // standard OKI step sizes
    localparam logic [11:0] step_table [0:48] = '{
        12'd16,   12'd17,   12'd19,   12'd21,   12'd23,   12'd25,   12'd28,
        12'd31,   12'd34,   12'd37,   12'd41,   12'd45,   12'd50,   12'd55,
        12'd60,   12'd66,   12'd73,   12'd80,   12'd88,   12'd97,   12'd107,
        12'd118,  12'd130,  12'd143,  12'd157,  12'd173,  12'd190,  12'd209,
        12'd230,  12'd253,  12'd279,  12'd307,  12'd337,  12'd371,  12'd408,
        12'd449,  12'd494,  12'd544,  12'd598,  12'd658,  12'd724,  12'd796,
        12'd876,  12'd963,  12'd1060, 12'd1166, 12'd1282, 12'd1411, 12'd1552
    };

    // index change, addressed by the nibble magnitude
    localparam logic signed [3:0] index_adjust [0:7] = '{
        -4'sd1, -4'sd1, -4'sd1, -4'sd1, 4'sd2, 4'sd4, 4'sd6, 4'sd8
    };

endpackage

//--- snd_params.svh
////////////////////////////////////////////////////////////////////////////
// sound board constants
// voice count, sample ROM address width, credit depth, tick divider
////////////////////////////////////////////////////////////////////////////

`ifndef SND_PARAMS_SVH
`define SND_PARAMS_SVH

// number of ADPCM voices, at most 2 with the 4-bit host map
`define SND_VOICES 2
// byte address width of each sample ROM
`define SND_ROM_AW 16
// credits per voice, same as mixer buffer depth
`define SND_CREDITS 2
// clock cycles per output sample
`define SND_TICK_DIV 128

`endif
